/* rtl/xfer_pkg.sv */
`default_nettype none

package xfer_pkg;

   ////////////////////
   // Sizes and timing
   ////////////////////

   localparam int NUM_REGS      = 4;   // Octal registers, also J-K flags
   localparam int SETTLE_CYCLES = 2;   // Bus settle wait states
   localparam int SETTLE_W      = $clog2(SETTLE_CYCLES + 1);

   typedef logic [7:0]          data_t;        // Register or bus byte
   typedef logic [1:0]          reg_idx_t;     // Register or flag index
   typedef logic [SETTLE_W-1:0] settle_cnt_t;  // Wait-state counter

   ////////////////////
   // Commands
   ////////////////////

   typedef enum logic [1:0] {
      OP_LOAD   = 2'b00,   // imm -> dst
      OP_MOVE   = 2'b01,   // src -> dst
      OP_INVERT = 2'b10,   // ~src -> dst, as on a 74x564
      OP_FLAG   = 2'b11    // J-K action on flag dst
   } xfer_op_e;

   // 14 bits, op in the top two
   // For OP_FLAG, imm[1] is J and imm[0] is K
   typedef struct packed {
      xfer_op_e op;
      reg_idx_t src;
      reg_idx_t dst;
      data_t    imm;
   } xfer_cmd_t;

   ////////////////////
   // Sequencer
   ////////////////////

   typedef enum logic [1:0] {
      ST_IDLE   = 2'b00,
      ST_DRIVE  = 2'b01,   // Source onto bus
      ST_SETTLE = 2'b10,   // Wait for bus to settle
      ST_LATCH  = 2'b11    // Clock destination
   } seq_state_e;

endpackage

`default_nettype wire

/* rtl/settle_timer.sv */
`timescale 1ns/1ps
`default_nettype none

// Bus settle wait-state counter
module settle_timer import xfer_pkg::*; (
   input  wire  clk,
   input  wire  rst,
   input  logic start,     // Pulse, loads the count
   output logic expired,   // High in last wait state
   output logic running
);

   settle_cnt_t cnt;   // Remaining wait states, 0 when idle

   always_ff @(posedge clk) begin
      if (!rst) begin
         cnt     <= '0;
         running <= 1'b0;
      end else if (start) begin
         cnt     <= settle_cnt_t'(SETTLE_CYCLES);
         running <= 1'b1;
      end else if (running) begin
         cnt <= cnt - settle_cnt_t'(1);   // Ends at 0 after expiry
         if (expired) begin
            running <= 1'b0;
         end
      end
   end

   // Last wait state
   assign expired = (cnt == settle_cnt_t'(1));

   ////////////////////
   // Checks
   ////////////////////

   // Count and running flag stay in step
   a_expired_running: assert property (
      @(posedge clk) disable iff (!rst)
      expired |-> running
   );

endmodule

`default_nettype wire

/* rtl/xfer_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

// One command at a time: drive, settle, latch
module xfer_sequencer import xfer_pkg::*; (
   input  wire        clk,
   input  wire        rst,
   input  logic       cmd_valid,      // One-cycle strobe
   input  xfer_cmd_t  cmd,
   input  logic       settle_done,
   output logic       settle_start,
   output logic       busy,
   output logic       done,
   output reg_idx_t   bus_sel,
   output logic       bus_inv,
   output logic       imm_sel,
   output data_t      imm,
   output logic       reg_we,
   output reg_idx_t   reg_wsel,
   output logic       flag_we,
   output reg_idx_t   flag_sel,
   output logic [1:0] flag_jk
);

   seq_state_e state;
   seq_state_e state_nxt;
   xfer_cmd_t  cmd_q;      // Command being run
   logic       accept;

   // Strobes while busy simply fall on the floor
   assign accept = cmd_valid && (state == ST_IDLE);

   ////////////////////
   // State machine
   ////////////////////

   always_comb begin
      state_nxt = state;
      unique case (state)
         ST_IDLE: begin
            if (accept) state_nxt = ST_DRIVE;
         end
         ST_DRIVE:  state_nxt = ST_SETTLE;   // Single cycle
         ST_SETTLE: begin
            if (settle_done) state_nxt = ST_LATCH;
         end
         ST_LATCH:  state_nxt = ST_IDLE;
         default:   state_nxt = ST_IDLE;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rst) begin
         state <= ST_IDLE;
      end else begin
         state <= state_nxt;
      end
   end

   // Holding register, loaded on acceptance only
   always_ff @(posedge clk) begin
      if (accept) begin
         cmd_q <= cmd;
      end
   end

   ////////////////////
   // Decode
   ////////////////////

   assign busy         = (state != ST_IDLE);
   assign settle_start = (state == ST_DRIVE);   // Kicks the timer
   assign done         = (state == ST_LATCH);

   // Bank side
   assign bus_sel  = cmd_q.src;
   assign bus_inv  = (cmd_q.op == OP_INVERT);
   assign imm_sel  = (cmd_q.op == OP_LOAD);
   assign imm      = cmd_q.imm;
   assign reg_wsel = cmd_q.dst;
   assign reg_we   = done && (cmd_q.op != OP_FLAG);

   // Flag side, dst picks the flag
   assign flag_sel = cmd_q.dst;
   assign flag_jk  = cmd_q.imm[1:0];   // {J, K}
   assign flag_we  = done && (cmd_q.op == OP_FLAG);

   ////////////////////
   // Checks
   ////////////////////

   // One destination per command
   a_we_onehot: assert property (
      @(posedge clk) disable iff (!rst)
      !(reg_we && flag_we)
   );

   a_state_legal: assert property (
      @(posedge clk) disable iff (!rst)
      !$isunknown(state) && (state inside {ST_IDLE, ST_DRIVE, ST_SETTLE, ST_LATCH})
   );

endmodule

`default_nettype wire

/* rtl/octal_reg_bank.sv */
`timescale 1ns/1ps
`default_nettype none

// Four octal registers on one internal bus
module octal_reg_bank import xfer_pkg::*; (
   input  wire      clk,
   input  wire      rst,
   input  reg_idx_t bus_sel,   // Register driving the bus
   input  logic     bus_inv,   // 74x564 style inversion
   input  logic     imm_sel,   // Immediate drives the bus
   input  data_t    imm,
   input  logic     we,
   input  reg_idx_t wsel,
   input  reg_idx_t rd_sel,
   output data_t    rd_data
);

   data_t regs [NUM_REGS];   // The 74x574 bank
   data_t bus_src;           // Selected driver
   data_t bus;               // Value seen by all D inputs

   ////////////////////
   // Bus multiplexer
   ////////////////////

   // Stands in for the shared tri-state bus
   assign bus_src = imm_sel ? imm : regs[bus_sel];
   assign bus     = bus_inv ? ~bus_src : bus_src;

   ////////////////////
   // Registers
   ////////////////////

   // Cleared on reset like a 74x273
   always_ff @(posedge clk) begin
      if (!rst) begin
         for (int i = 0; i < NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (we) begin
         regs[wsel] <= bus;   // Only the clocked chip changes
      end
   end

   // Read-back, no delay
   assign rd_data = regs[rd_sel];

endmodule

`default_nettype wire

/* rtl/jk_flag_reg.sv */
`timescale 1ns/1ps
`default_nettype none

// Four J-K status flags, 74x112 truth table
module jk_flag_reg import xfer_pkg::*; (
   input  wire                 clk,
   input  wire                 rst,
   input  logic                we,      // Clock enable for selected flag
   input  reg_idx_t            sel,
   input  logic [1:0]          jk,      // {J, K}
   output logic [NUM_REGS-1:0] flags
);

   logic flag_nxt;   // Next value of selected flag

   // J-K table
   function automatic logic jk_next(input logic [1:0] jk_in, input logic q);
      logic q_n;
      unique case (jk_in)
         2'b00:   q_n = q;      // Hold
         2'b01:   q_n = 1'b0;   // Clear
         2'b10:   q_n = 1'b1;   // Set
         default: q_n = ~q;     // Toggle
      endcase
      return q_n;
   endfunction

   assign flag_nxt = jk_next(jk, flags[sel]);

   always_ff @(posedge clk) begin
      if (!rst) begin
         flags <= '0;
      end else if (we) begin
         flags[sel] <= flag_nxt;   // Others keep their value
      end
   end

endmodule

`default_nettype wire

/* rtl/bus_xfer_unit.sv */
`timescale 1ns/1ps
`default_nettype none

// Register-transfer block, top level
module bus_xfer_unit import xfer_pkg::*; (
   input  wire                 clk,
   input  wire                 rst,
   input  logic                cmd_valid,
   input  xfer_cmd_t           cmd,
   input  reg_idx_t            rd_sel,
   output logic                busy,
   output logic                done,
   output data_t               rd_data,
   output logic [NUM_REGS-1:0] flags
);

   ////////////////////
   // Internal wiring
   ////////////////////

   logic       settle_start;
   logic       settle_done;
   logic       settle_running;   // Not needed by the sequencer

   reg_idx_t   bus_sel;
   logic       bus_inv;
   logic       imm_sel;
   data_t      imm;
   logic       reg_we;
   reg_idx_t   reg_wsel;

   logic       flag_we;
   reg_idx_t   flag_sel;
   logic [1:0] flag_jk;

   xfer_sequencer u_seq (
      .clk          (clk),
      .rst          (rst),
      .cmd_valid    (cmd_valid),
      .cmd          (cmd),
      .settle_done  (settle_done),
      .settle_start (settle_start),
      .busy         (busy),
      .done         (done),
      .bus_sel      (bus_sel),
      .bus_inv      (bus_inv),
      .imm_sel      (imm_sel),
      .imm          (imm),
      .reg_we       (reg_we),
      .reg_wsel     (reg_wsel),
      .flag_we      (flag_we),
      .flag_sel     (flag_sel),
      .flag_jk      (flag_jk)
   );

   settle_timer u_timer (
      .clk     (clk),
      .rst     (rst),
      .start   (settle_start),
      .expired (settle_done),
      .running (settle_running)
   );

   octal_reg_bank u_bank (
      .clk     (clk),
      .rst     (rst),
      .bus_sel (bus_sel),
      .bus_inv (bus_inv),
      .imm_sel (imm_sel),
      .imm     (imm),
      .we      (reg_we),
      .wsel    (reg_wsel),
      .rd_sel  (rd_sel),
      .rd_data (rd_data)
   );

   jk_flag_reg u_flags (
      .clk   (clk),
      .rst   (rst),
      .we    (flag_we),
      .sel   (flag_sel),
      .jk    (flag_jk),
      .flags (flags)
   );

   // Timer only runs inside a command
   a_timer_busy: assert property (
      @(posedge clk) disable iff (!rst)
      settle_running |-> busy
   );

endmodule

`default_nettype wire

/* dv/bus_xfer_unit_tb.sv */
`timescale 1ns/1ps
`default_nettype none

// Testbench for the register-transfer block
module bus_xfer_unit_tb import xfer_pkg::*; ();

   localparam int LATENCY  = 2 + SETTLE_CYCLES;   // Accept edge to done
   localparam int TIMEOUT  = 20;                  // Falling edges before giving up
   localparam int NUM_VECS = 15;
   localparam int NUM_RAND = 24;

   typedef struct packed {
      xfer_cmd_t cmd;
      logic      inject;   // Second strobe while busy
   } vec_t;

   logic                clk;
   logic                rst;
   logic                cmd_valid;
   xfer_cmd_t           cmd;
   reg_idx_t            rd_sel;
   logic                busy;
   logic                done;
   data_t               rd_data;
   logic [NUM_REGS-1:0] flags;

   data_t               m_regs [NUM_REGS];   // Reference registers
   logic [NUM_REGS-1:0] m_flags;             // Reference flags
   vec_t                vecs [NUM_VECS];
   int                  errors;
   int                  checks;
   int                  seed;
   logic                timed_out;           // done never came, stop issuing

   bus_xfer_unit UUT (
      .clk       (clk),
      .rst       (rst),
      .cmd_valid (cmd_valid),
      .cmd       (cmd),
      .rd_sel    (rd_sel),
      .busy      (busy),
      .done      (done),
      .rd_data   (rd_data),
      .flags     (flags)
   );

   always #5 clk = ~clk;   // 10 ns period

   ////////////////////
   // Helpers
   ////////////////////

   function automatic vec_t make_vec(input xfer_op_e op, input reg_idx_t src,
                                     input reg_idx_t dst, input data_t imm, input logic inj);
      vec_t v;
      v.cmd.op  = op;
      v.cmd.src = src;
      v.cmd.dst = dst;
      v.cmd.imm = imm;
      v.inject  = inj;
      return v;
   endfunction

   // Register and flag rules of the block
   function automatic void apply_model(input xfer_cmd_t c);
      logic [1:0] jk;
      jk = c.imm[1:0];   // {J, K}
      case (c.op)
         OP_LOAD:   m_regs[c.dst] = c.imm;
         OP_MOVE:   m_regs[c.dst] = m_regs[c.src];
         OP_INVERT: m_regs[c.dst] = ~m_regs[c.src];
         default: begin
            if (jk == 2'b10) m_flags[c.dst] = 1'b1;          // Set
            else if (jk == 2'b01) m_flags[c.dst] = 1'b0;     // Clear
            else if (jk == 2'b11) m_flags[c.dst] = !m_flags[c.dst];
         end
      endcase
   endfunction

   task automatic compare(input string name, input logic [7:0] got, input logic [7:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("** Error: %s = 0x%02h, expected 0x%02h at %0t", name, got, exp, $time);
      end
   endtask

   // One register per falling edge through rd_sel
   task automatic check_state();
      for (int i = 0; i < NUM_REGS; i++) begin
         rd_sel = reg_idx_t'(i);
         @(negedge clk);
         compare($sformatf("rd_data[%0d]", i), rd_data, m_regs[i]);
      end
      compare("flags", {4'h0, flags}, {4'h0, m_flags});
   endtask

   task automatic finish_run();
      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("*** PASSED ***");
      end else begin
         $display("*** FAILED ***");
      end
      $finish;
   endtask

   // Starts and ends on a falling edge
   task automatic run_cmd(input vec_t v);
      xfer_cmd_t stray;
      int        cycles;
      stray     = v.cmd;
      stray.op  = OP_LOAD;          // Would clobber a neighbour if taken
      stray.dst = v.cmd.dst ^ 2'd1;
      stray.imm = 8'h5A;
      cmd       = v.cmd;
      cmd_valid = 1'b1;
      @(negedge clk);               // Accepting edge just passed
      cycles    = 1;
      cmd_valid = 1'b0;
      while (done !== 1'b1 && cycles < TIMEOUT) begin
         compare("busy", {7'h0, busy}, 8'h01);
         if (v.inject && cycles == 1) begin
            cmd       = stray;      // Lands in ST_DRIVE
            cmd_valid = 1'b1;
         end else begin
            cmd_valid = 1'b0;
         end
         @(negedge clk);
         cycles++;
      end
      cmd_valid = 1'b0;
      if (done !== 1'b1) begin
         $display("Timeout: done never came for command 0x%04h", v.cmd);
         errors++;
         timed_out = 1'b1;
      end else begin
         compare("latency", 8'(cycles), 8'(LATENCY));
         compare("busy", {7'h0, busy}, 8'h01);
         apply_model(v.cmd);
         @(negedge clk);            // Write has landed
         compare("done", {7'h0, done}, 8'h00);
         compare("busy", {7'h0, busy}, 8'h00);
         check_state();
      end
   endtask

   ////////////////////
   // Main sequence
   ////////////////////

   initial begin
      logic [31:0] r;
      xfer_op_e    op;
      clk       = 1'b0;
      rst       = 1'b0;
      cmd_valid = 1'b0;
      cmd       = '0;
      rd_sel    = '0;
      errors    = 0;
      checks    = 0;
      timed_out = 1'b0;
      seed      = 32'hf538_1fe0;
      for (int i = 0; i < NUM_REGS; i++) begin
         m_regs[i] = '0;
      end
      m_flags = '0;

      // Directed table, op src dst imm inject
      vecs[0]  = make_vec(OP_LOAD,   2'd0, 2'd0, 8'hA5, 1'b0);
      vecs[1]  = make_vec(OP_LOAD,   2'd0, 2'd1, 8'h3C, 1'b1);
      vecs[2]  = make_vec(OP_MOVE,   2'd0, 2'd2, 8'h00, 1'b0);
      vecs[3]  = make_vec(OP_MOVE,   2'd1, 2'd1, 8'h77, 1'b0);   // src equals dst
      vecs[4]  = make_vec(OP_INVERT, 2'd0, 2'd3, 8'h00, 1'b0);
      vecs[5]  = make_vec(OP_INVERT, 2'd3, 2'd3, 8'h00, 1'b1);
      vecs[6]  = make_vec(OP_LOAD,   2'd1, 2'd2, 8'hFF, 1'b0);
      vecs[7]  = make_vec(OP_MOVE,   2'd2, 2'd0, 8'h00, 1'b1);
      vecs[8]  = make_vec(OP_FLAG,   2'd0, 2'd0, 8'hF2, 1'b0);   // Set
      vecs[9]  = make_vec(OP_FLAG,   2'd0, 2'd1, 8'h02, 1'b0);
      vecs[10] = make_vec(OP_FLAG,   2'd0, 2'd0, 8'h01, 1'b0);   // Clear
      vecs[11] = make_vec(OP_FLAG,   2'd0, 2'd1, 8'h03, 1'b0);   // Toggle to 0
      vecs[12] = make_vec(OP_FLAG,   2'd0, 2'd2, 8'hC3, 1'b0);   // Toggle to 1
      vecs[13] = make_vec(OP_FLAG,   2'd0, 2'd2, 8'h00, 1'b1);   // Hold
      vecs[14] = make_vec(OP_FLAG,   2'd0, 2'd3, 8'h01, 1'b0);

      repeat (8) @(negedge clk);
      rst = 1'b1;

      // Reset values
      compare("busy", {7'h0, busy}, 8'h00);
      compare("done", {7'h0, done}, 8'h00);
      check_state();

      for (int n = 0; n < NUM_VECS && !timed_out; n++) begin
         run_cmd(vecs[n]);
      end

      // Random Load and Move
      for (int n = 0; n < NUM_RAND && !timed_out; n++) begin
         r = $random(seed);
         if (r[0]) op = OP_MOVE;
         else op = OP_LOAD;
         run_cmd(make_vec(op, r[3:2], r[5:4], r[15:8], r[16]));
      end

      finish_run();
   end

endmodule

`default_nettype wire

/* filelist.f */
rtl/xfer_pkg.sv
rtl/settle_timer.sv
rtl/xfer_sequencer.sv
rtl/octal_reg_bank.sv
rtl/jk_flag_reg.sv
rtl/bus_xfer_unit.sv
dv/bus_xfer_unit_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the testbench with Verilator
set -eo pipefail

cd "$(dirname "$0")"

LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --assert \
   --top-module bus_xfer_unit_tb \
   -f filelist.f

./obj_dir/Vbus_xfer_unit_tb | tee "$LOG"

if grep -qF '*** PASSED ***' "$LOG"; then
   echo "Simulation passed"
else
   echo "Simulation failed, see $LOG"
   exit 1
fi
